// File: rtl/rv32_config.svh
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

// **********************************************************************
// Datapath sizing of the execution unit
// **********************************************************************

// Register and operand width
`define RV_XLEN 32

// Shift amount taken from the low bits of opB
`define RV_SHAMT_W 5

// One quotient bit per divider iteration
`define RV_DIV_STEPS 32

`endif

// File: rtl/rvIsaPkg.sv
package rvIsaPkg;

   // funct3 field as it arrives from the decoder
   typedef logic [2:0] funct3T;

   // **********************************************************************
   // RV32I register/immediate operations
   // **********************************************************************
   localparam funct3T f3Add  = 3'b000; // Also SUB when alt is set
   localparam funct3T f3Sll  = 3'b001;
   localparam funct3T f3Slt  = 3'b010;
   localparam funct3T f3Sltu = 3'b011;
   localparam funct3T f3Xor  = 3'b100;
   localparam funct3T f3Srl  = 3'b101; // Also SRA when alt is set
   localparam funct3T f3Or   = 3'b110;
   localparam funct3T f3And  = 3'b111;

   // Branch comparisons
   localparam funct3T f3Beq  = 3'b000;
   localparam funct3T f3Bne  = 3'b001;
   localparam funct3T f3Blt  = 3'b100;
   localparam funct3T f3Bge  = 3'b101;
   localparam funct3T f3Bltu = 3'b110;
   localparam funct3T f3Bgeu = 3'b111;

   // **********************************************************************
   // RV32M multiply and divide
   // **********************************************************************
   localparam funct3T f3Mul    = 3'b000; // Low product word
   localparam funct3T f3Mulh   = 3'b001; // High word, signed x signed
   localparam funct3T f3Mulhsu = 3'b010; // High word, signed x unsigned
   localparam funct3T f3Mulhu  = 3'b011; // High word, unsigned x unsigned
   localparam funct3T f3Div    = 3'b100;
   localparam funct3T f3Divu   = 3'b101;
   localparam funct3T f3Rem    = 3'b110;
   localparam funct3T f3Remu   = 3'b111;

   // Which unit answers the request
   typedef enum logic [1:0] {
      opInt,    // ALU reg/imm result
      opBranch, // Predicate only
      opMulDiv  // RV32M
   } opKindT;

endpackage

// File: rtl/rvAluPkg.sv
`include "rv32_config.svh"

package rvAluPkg;

   // **********************************************************************
   // Datapath words
   // **********************************************************************
   typedef logic [`RV_XLEN-1:0]   wordT;    // Operand or result
   typedef logic [2*`RV_XLEN-1:0] dwordT;   // Full product
   typedef logic [`RV_SHAMT_W-1:0] shamtT;  // Shift amount

   // Divider iteration counter
   typedef logic [$clog2(`RV_DIV_STEPS)-1:0] stepCntT;

   // **********************************************************************
   // Request, partial result and response
   // **********************************************************************
   typedef struct packed {
      logic            start;  // One-cycle strobe
      rvIsaPkg::opKindT kind;
      rvIsaPkg::funct3T funct3;
      logic            alt;    // SUB / SRA select
      wordT            opA;
      wordT            opB;
   } aluReqT;

   // Answer of one unit before the response register
   typedef struct packed {
      logic ready;
      wordT value;
      logic predicate;
   } partResT;

   // Registered answer towards the requester
   typedef struct packed {
      logic done;      // Single-cycle pulse
      wordT value;     // Held until next done
      logic predicate;
   } aluRspT;

endpackage

// File: rtl/intUnit.sv
`include "rv32_config.svh"

module intUnit (
   input  rvAluPkg::aluReqT  req,
   output rvAluPkg::partResT intRes
);
   import rvIsaPkg::*;
   import rvAluPkg::*;

   // Bit reversal lets one right shifter do left shifts too
   function automatic wordT flip(input wordT x);
      wordT y;
      for (int i = 0; i < `RV_XLEN; i++) begin
         y[i] = x[`RV_XLEN-1-i];
      end
      return y;
   endfunction

   wordT                      sum;
   logic [`RV_XLEN:0]         minus;    // Carry bit gives unsigned less-than
   logic                      lt;
   logic                      ltu;
   logic                      eq;
   shamtT                     shamt;
   wordT                      shIn;
   logic signed [`RV_XLEN:0]  shExt;    // Extra MSB carries the SRA fill bit
   logic [`RV_XLEN:0]         shOut;
   wordT                      aluVal;
   logic                      pred;
   logic                      isInt;
   logic                      isBranch;

   // **********************************************************************
   // Adder and the shared 33-bit subtraction
   // **********************************************************************
   assign sum   = req.opA + req.opB;
   assign minus = {1'b1, ~req.opB} + {1'b0, req.opA} + 1'b1;

   // Differing signs decide signed order directly
   assign lt  = (req.opA[`RV_XLEN-1] ^ req.opB[`RV_XLEN-1]) ?
                req.opA[`RV_XLEN-1] : minus[`RV_XLEN];
   assign ltu = minus[`RV_XLEN];
   assign eq  = (minus[`RV_XLEN-1:0] == '0);

   // **********************************************************************
   // Shifter
   // **********************************************************************
   assign shamt = req.opB[`RV_SHAMT_W-1:0];
   assign shIn  = req.funct3[2] ? req.opA : flip(req.opA); // funct3[2] set for SRL/SRA
   assign shExt = {req.alt & req.funct3[2] & req.opA[`RV_XLEN-1], shIn};
   assign shOut = shExt >>> shamt;

   // ALU result
   always_comb begin
      case (req.funct3)
         f3Add:   aluVal = req.alt ? minus[`RV_XLEN-1:0] : sum;
         f3Sll:   aluVal = flip(shOut[`RV_XLEN-1:0]);
         f3Slt:   aluVal = wordT'(lt);
         f3Sltu:  aluVal = wordT'(ltu);
         f3Xor:   aluVal = req.opA ^ req.opB;
         f3Srl:   aluVal = shOut[`RV_XLEN-1:0]; // SRL or SRA
         f3Or:    aluVal = req.opA | req.opB;
         f3And:   aluVal = req.opA & req.opB;
         default: aluVal = '0;
      endcase
   end

   // Branch predicate where codes 010 and 011 are not branches
   always_comb begin
      case (req.funct3)
         f3Beq:   pred = eq;
         f3Bne:   pred = ~eq;
         f3Blt:   pred = lt;
         f3Bge:   pred = ~lt;
         f3Bltu:  pred = ltu;
         f3Bgeu:  pred = ~ltu;
         default: pred = 1'b0;
      endcase
   end

   assign isInt    = (req.kind == opInt);
   assign isBranch = (req.kind == opBranch);

   // Answer in the start cycle
   assign intRes.ready     = req.start & (isInt | isBranch);
   assign intRes.value     = isInt ? aluVal : '0;
   assign intRes.predicate = isBranch & pred;

endmodule

// File: rtl/mulDivUnit.sv
`include "rv32_config.svh"

module mulDivUnit (
   input  logic              clk,
   input  logic              reset,
   input  rvAluPkg::aluReqT  req,
   output rvAluPkg::partResT mdRes,
   output logic              mdBusy
);
   import rvIsaPkg::*;
   import rvAluPkg::*;

   typedef enum logic [1:0] {
      divIdle,
      divStep,
      divFixup
   } divStateT;

   logic                          isMulDiv;
   logic                          mulReady;
   logic                          divStart;
   logic                          signA;
   logic                          signB;
   logic signed [`RV_XLEN:0]      mulA;
   logic signed [`RV_XLEN:0]      mulB;
   logic signed [2*`RV_XLEN+1:0]  prodFull;
   dwordT                         product;
   wordT                          mulVal;

   logic                          signedDiv;
   logic                          remReq;
   wordT                          absA;
   wordT                          absB;
   logic                          signNext;

   divStateT                      divState;
   stepCntT                       stepCnt;
   wordT                          dividend;    // Ends up as the remainder
   logic [2*`RV_XLEN-2:0]         divisor;     // Starts at |opB| << (XLEN-1)
   wordT                          quotient;
   logic                          divSign;     // Negate result in fix-up
   logic                          isRem;
   logic                          geq;
   wordT                          divVal;

   assign isMulDiv = req.start & (req.kind == opMulDiv);
   assign mulReady = isMulDiv & (req.funct3 inside {f3Mul, f3Mulh, f3Mulhsu, f3Mulhu});
   assign divStart = isMulDiv & (req.funct3 inside {f3Div, f3Divu, f3Rem, f3Remu});

   // **********************************************************************
   // Single-cycle 33x33 signed multiply
   // **********************************************************************
   assign signA    = req.opA[`RV_XLEN-1] & (req.funct3 != f3Mulhu);
   assign signB    = req.opB[`RV_XLEN-1] & (req.funct3 == f3Mul || req.funct3 == f3Mulh);
   assign mulA     = {signA, req.opA};
   assign mulB     = {signB, req.opB};
   assign prodFull = mulA * mulB;
   assign product  = prodFull[2*`RV_XLEN-1:0];
   assign mulVal   = (req.funct3 == f3Mul) ? product[`RV_XLEN-1:0]
                                           : product[2*`RV_XLEN-1:`RV_XLEN];

   // **********************************************************************
   // Divider load values
   // **********************************************************************
   assign signedDiv = (req.funct3 == f3Div) || (req.funct3 == f3Rem);
   assign remReq    = (req.funct3 == f3Rem) || (req.funct3 == f3Remu);
   assign absA = (signedDiv & req.opA[`RV_XLEN-1]) ? -req.opA : req.opA;
   assign absB = (signedDiv & req.opB[`RV_XLEN-1]) ? -req.opB : req.opB;

   // REM takes the dividend sign, DIV the sign difference unless dividing by zero
   assign signNext = signedDiv & (remReq ? req.opA[`RV_XLEN-1]
                     : (req.opA[`RV_XLEN-1] ^ req.opB[`RV_XLEN-1]) & (|req.opB));

   // Restoring step compare
   assign geq = (divisor <= {{(`RV_XLEN-1){1'b0}}, dividend});

   // **********************************************************************
   // Divider FSM
   // **********************************************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         divState <= divIdle;
         stepCnt  <= '0;
      end else begin
         case (divState)
            divIdle: begin
               if (divStart) begin
                  divState <= divStep;
                  stepCnt  <= '0;
               end
            end
            divStep: begin
               stepCnt <= stepCnt + 1'b1;
               if (stepCnt == stepCntT'(`RV_DIV_STEPS-1)) begin
                  divState <= divFixup; // Last quotient bit this edge
               end
            end
            divFixup: divState <= divIdle; // Merge takes the result here
            default:  divState <= divIdle;
         endcase
      end
   end

   // Datapath registers load on start and shift once per step
   always_ff @(posedge clk) begin
      if (divState == divIdle && divStart) begin
         dividend <= absA;
         divisor  <= {absB, {(`RV_XLEN-1){1'b0}}};
         quotient <= '0;
         divSign  <= signNext;
         isRem    <= remReq;
      end else if (divState == divStep) begin
         divisor  <= divisor >> 1;
         quotient <= {quotient[`RV_XLEN-2:0], geq}; // MSB first
         if (geq) begin
            dividend <= dividend - divisor[`RV_XLEN-1:0];
         end
      end
   end

   // Sign fix-up of quotient or remainder
   always_comb begin
      case ({isRem, divSign})
         2'b00:   divVal = quotient;
         2'b01:   divVal = -quotient;
         2'b10:   divVal = dividend;
         default: divVal = -dividend;
      endcase
   end

   // Busy from load until the fix-up cycle has been registered
   assign mdBusy = (divState != divIdle);

   assign mdRes.ready     = mulReady | (divState == divFixup);
   assign mdRes.value     = (divState == divFixup) ? divVal : mulVal;
   assign mdRes.predicate = 1'b0; // No compare from RV32M

endmodule

// File: rtl/resultMerge.sv
module resultMerge (
   input  logic              clk,
   input  logic              reset,
   input  rvAluPkg::partResT intRes,
   input  rvAluPkg::partResT mdRes,
   input  logic              mdBusy,
   output rvAluPkg::aluRspT  rsp,
   output logic              busy
);

   // **********************************************************************
   // Response register
   // **********************************************************************
   // At most one unit is ready in a cycle since start is blocked while busy
   always_ff @(posedge clk) begin
      if (!reset) begin
         rsp <= '0;
      end else begin
         rsp.done <= intRes.ready | mdRes.ready; // One pulse per answer

         // Value and predicate hold until the next answer
         if (intRes.ready) begin
            rsp.value     <= intRes.value;
            rsp.predicate <= intRes.predicate;
         end else if (mdRes.ready) begin
            rsp.value     <= mdRes.value;
            rsp.predicate <= mdRes.predicate;
         end
      end
   end

   // Only the divider is ever multi-cycle
   assign busy = mdBusy;

endmodule

// File: rtl/rvAluTop.sv
module rvAluTop (
   input  logic             clk,
   input  logic             reset,
   input  rvAluPkg::aluReqT req,
   output rvAluPkg::aluRspT rsp,
   output logic             busy
);
   import rvAluPkg::*;

   partResT intRes;   // RV32I and branch answer
   partResT mdRes;    // RV32M answer
   logic    mdBusy;   // Divider running

   // **********************************************************************
   // Units side by side merged into one response
   // **********************************************************************
   intUnit u_intUnit (
      .req    (req),
      .intRes (intRes)
   );

   mulDivUnit u_mulDivUnit (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .mdRes  (mdRes),
      .mdBusy (mdBusy)
   );

   resultMerge u_resultMerge (
      .clk    (clk),
      .reset  (reset),
      .intRes (intRes),
      .mdRes  (mdRes),
      .mdBusy (mdBusy),
      .rsp    (rsp),
      .busy   (busy)
   );

endmodule

// File: sim/tbRvAlu.sv
`include "rv32_config.svh"

module tbRvAlu;
   timeunit 1ns;
   timeprecision 1ps;

   import rvIsaPkg::*;
   import rvAluPkg::*;

   // **********************************************************************
   // Run length and timeout
   // **********************************************************************
   localparam int nRand         = 4;                          // Random pairs per operation
   localparam int nSingleOps    = 14 * (16 + nRand) + 6 * (17 + nRand);
   localparam int nDivOps       = 4 * 10;
   localparam int plannedCycles = 2 * nSingleOps + (`RV_DIV_STEPS + 3) * nDivOps + 10;
   localparam int cycleLimit    = plannedCycles * 3 / 2;

   logic   clk;
   logic   reset;
   aluReqT req;
   aluRspT rsp;
   logic   busy;

   logic [31:0] lfsrState = 32'd17;  // Seed
   int          cycleCnt  = 0;
   int          checkCount = 0;

   // Monitor state
   logic pend     = 1'b0;
   int   age      = 0;     // Rising edges since the start edge
   int   expLat   = 0;     // Edge that registers the answer
   logic expDiv   = 1'b0;
   wordT expVal   = '0;
   logic expPred  = 1'b0;
   wordT heldVal  = '0;    // Last answer which reset clears
   logic heldPred = 1'b0;

   wordT   edgeVals[4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
   funct3T intF3[10]   = '{f3Add, f3Add, f3Sll, f3Slt, f3Sltu, f3Xor, f3Srl, f3Srl, f3Or, f3And};
   logic   intAlt[10]  = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
   funct3T brF3[6]     = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
   funct3T mulF3[4]    = '{f3Mul, f3Mulh, f3Mulhsu, f3Mulhu};
   funct3T divF3[4]    = '{f3Div, f3Divu, f3Rem, f3Remu};

   rvAluTop u_rvAluTop (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .rsp   (rsp),
      .busy  (busy)
   );

   always #4 clk = ~clk; // 8 ns period

   // **********************************************************************
   // Failure reporting and random source
   // **********************************************************************
   task automatic failRun(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic reportMismatch(input string sigName, input wordT expV, input wordT gotV);
      failRun($sformatf("ERR %s expected 0x%08h observed 0x%08h", sigName, expV, gotV));
   endtask

   // Taps of x^32 + x^22 + x^2 + x + 1 with one step per bit
   function automatic logic lfsrBit();
      logic fb;
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      return fb;
   endfunction

   function automatic wordT randWord();
      wordT w;
      for (int i = 0; i < `RV_XLEN; i++) begin
         w = {w[`RV_XLEN-2:0], lfsrBit()};
      end
      return w;
   endfunction

   // **********************************************************************
   // Reference model from the RISC-V rules
   // **********************************************************************
   function automatic void expectedResult(input aluReqT r, output wordT val, output logic pred);
      wordT   a;
      wordT   b;
      int     sa;
      int     sb;
      longint pa;
      longint pb;
      longint prod;
      shamtT  sh;
      a    = r.opA;
      b    = r.opB;
      sa   = a;                       // Signed views
      sb   = b;
      sh   = b[`RV_SHAMT_W-1:0];
      val  = '0;
      pred = 1'b0;
      case (r.kind)
         opInt: begin
            case (r.funct3)
               f3Add:  val = r.alt ? a - b : a + b;
               f3Sll:  val = a << sh;
               f3Slt:  val = (sa < sb) ? 32'd1 : 32'd0;
               f3Sltu: val = (a < b) ? 32'd1 : 32'd0;
               f3Xor:  val = a ^ b;
               f3Srl:  val = r.alt ? wordT'(sa >>> sh) : a >> sh;
               f3Or:   val = a | b;
               default: val = a & b;
            endcase
         end
         opBranch: begin
            case (r.funct3)
               f3Beq:  pred = (a == b);
               f3Bne:  pred = (a != b);
               f3Blt:  pred = (sa < sb);
               f3Bge:  pred = (sa >= sb);
               f3Bltu: pred = (a < b);
               default: pred = (a >= b);
            endcase
         end
         default: begin
            pa = r.funct3 == f3Mulhu ? longint'({32'h0, a}) : longint'(sa);
            pb = (r.funct3 inside {f3Mulhsu, f3Mulhu}) ? longint'({32'h0, b}) : longint'(sb);
            prod = pa * pb;                                   // Low 64 bits exact
            case (r.funct3)
               f3Mul:  val = prod[31:0];
               f3Mulh, f3Mulhsu, f3Mulhu: val = prod[63:32];
               f3Div:  val = (b == 0) ? '1
                           : (a == 32'h8000_0000 && b == '1) ? a : wordT'(sa / sb);
               f3Divu: val = (b == 0) ? '1 : a / b;
               f3Rem:  val = (b == 0) ? a
                           : (a == 32'h8000_0000 && b == '1) ? '0 : wordT'(sa % sb);
               default: val = (b == 0) ? a : a % b;           // REMU
            endcase
         end
      endcase
   endfunction

   // **********************************************************************
   // Checkers sample on the rising edge before the DUT updates
   // **********************************************************************
   always @(posedge clk) begin
      if (reset) begin
         if (pend) begin
            age++;
            if (age == expLat + 1) begin                      // Answer registered last edge
               assert (rsp.done) else failRun("No done pulse in the expected cycle");
               assert (rsp.value == expVal) else reportMismatch("rsp.value", expVal, rsp.value);
               assert (rsp.predicate == expPred)
                  else reportMismatch("rsp.predicate", wordT'(expPred), wordT'(rsp.predicate));
               assert (!busy) else failRun("Busy still high when done arrived");
               heldVal  = expVal;
               heldPred = expPred;
               pend     = 1'b0;
               checkCount++;
            end else begin
               assert (!rsp.done) else failRun("Done pulse arrived before the result was due");
               assert (busy == expDiv) else reportMismatch("busy", wordT'(expDiv), wordT'(busy));
               assert (rsp.value == heldVal) else reportMismatch("rsp.value", heldVal, rsp.value);
               assert (rsp.predicate == heldPred)
                  else reportMismatch("rsp.predicate", wordT'(heldPred), wordT'(rsp.predicate));
            end
         end else begin
            // Idle including right after reset
            assert (!rsp.done) else failRun("Done pulse without a pending request");
            assert (!busy) else failRun("Busy high with no divide running");
            assert (rsp.value == heldVal) else reportMismatch("rsp.value", heldVal, rsp.value);
            assert (rsp.predicate == heldPred)
               else reportMismatch("rsp.predicate", wordT'(heldPred), wordT'(rsp.predicate));
         end
         if (req.start) begin
            expectedResult(req, expVal, expPred);
            expDiv = (req.kind == opMulDiv) && (req.funct3 inside {f3Div, f3Divu, f3Rem, f3Remu});
            expLat = expDiv ? `RV_DIV_STEPS + 1 : 0;          // Divide takes load, steps and fix-up
            age    = 0;
            pend   = 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      cycleCnt++;
      if (cycleCnt > cycleLimit) begin
         failRun($sformatf("Timeout: run did not finish within %0d cycles", cycleLimit));
      end
   end

   // **********************************************************************
   // Stimulus driven on the falling edge
   // **********************************************************************
   task automatic runOp(input opKindT kind, input funct3T f3, input logic alt,
                        input wordT a, input wordT b);
      aluReqT r;
      r.start  = 1'b1;
      r.kind   = kind;
      r.funct3 = f3;
      r.alt    = alt;
      r.opA    = a;
      r.opB    = b;
      @(negedge clk);
      req = r;
      @(negedge clk);
      req.start = 1'b0;                                       // One-cycle strobe
      while (!rsp.done) begin
         @(negedge clk);
      end
   endtask

   // All edge-value pairs, then random ones
   task automatic sweepPairs(input opKindT kind, input funct3T f3, input logic alt);
      wordT a;
      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4; j++) begin
            runOp(kind, f3, alt, edgeVals[i], edgeVals[j]);
         end
      end
      for (int k = 0; k < nRand; k++) begin
         a = randWord();
         runOp(kind, f3, alt, a, randWord());
      end
   endtask

   task automatic sweepDivides(input funct3T f3);
      wordT a;
      wordT b;
      runOp(opMulDiv, f3, 1'b0, randWord(), 32'h0);           // Divide by zero
      runOp(opMulDiv, f3, 1'b0, 32'h0, 32'h0);
      runOp(opMulDiv, f3, 1'b0, 32'h8000_0000, 32'hffff_ffff); // Signed overflow
      runOp(opMulDiv, f3, 1'b0, 32'hffff_ffff, 32'h1);
      runOp(opMulDiv, f3, 1'b0, randWord(), 32'hffff_ffff);
      runOp(opMulDiv, f3, 1'b0, 32'h8000_0000, 32'h1);
      for (int k = 0; k < 4; k++) begin
         a = randWord();
         b = randWord();
         b = b >> b[4:0];                                     // Spread divisor sizes
         runOp(opMulDiv, f3, 1'b0, a, b);
      end
   endtask

   initial begin
      clk   = 1'b0;
      reset = 1'b0;
      req   = '0;
      repeat (2) @(negedge clk);                              // Two reset edges
      reset = 1'b1;
      repeat (3) @(negedge clk);                              // Idle check after reset

      for (int i = 0; i < 10; i++) begin
         sweepPairs(opInt, intF3[i], intAlt[i]);
      end
      for (int i = 0; i < 6; i++) begin
         sweepPairs(opBranch, brF3[i], 1'b0);
         begin
            wordT eqVal;
            eqVal = randWord();
            runOp(opBranch, brF3[i], 1'b0, eqVal, eqVal);     // Equal pair
         end
      end
      for (int i = 0; i < 4; i++) begin
         sweepPairs(opMulDiv, mulF3[i], 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
         sweepDivides(divF3[i]);
      end

      repeat (2) @(negedge clk);                              // Last check and hold
      if (checkCount == 0) begin
         failRun("No response was checked");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule

// File: compile.f
+incdir+rtl
rtl/rvIsaPkg.sv
rtl/rvAluPkg.sv
rtl/intUnit.sv
rtl/mulDivUnit.sv
rtl/resultMerge.sv
rtl/rvAluTop.sv
sim/tbRvAlu.sv

// File: Bender.yml
package:
  name: rv32_alu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rvIsaPkg.sv
      - rtl/rvAluPkg.sv
      - rtl/intUnit.sv
      - rtl/mulDivUnit.sv
      - rtl/resultMerge.sv
      - rtl/rvAluTop.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tbRvAlu.sv
